//--- hdl/mem_consts.svh
// ------------------------------------------------
// Memory server widths and depths
// Message field sizes, array size and queue depth
// ------------------------------------------------

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Message field widths
`define MEM_ADDR_BITS  32
`define MEM_DATA_BITS  32
`define MEM_OPAQ_BITS  8

// One mask bit per data byte
`define MEM_LEN_BITS   4

// Word array, indexed by address bits 9 down to 2
`define MEM_WORDS      256
`define MEM_INDEX_BITS 8

// Default queue depth
`define MSG_FIFO_DEPTH 4

`endif

//--- hdl/mem_msg_pkg.sv
// ------------------------------------------------
// Memory message types
// Opcode and the request and response structs
// ------------------------------------------------

`include "mem_consts.svh"

package mem_msg_pkg;

  // ------------------------------------------------
  // Opcode
  // ------------------------------------------------

  typedef enum logic [0:0] {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // ------------------------------------------------
  // Request, 77 bits
  // ------------------------------------------------

  typedef struct packed {
    mem_op_e                    op;
    logic [`MEM_OPAQ_BITS-1:0] opaque;
    logic [`MEM_ADDR_BITS-1:0] addr;
    logic [`MEM_LEN_BITS-1:0]  len;
    logic [`MEM_DATA_BITS-1:0] data;
  } mem_req_t;

  // ------------------------------------------------
  // Response, same layout as the request
  // ------------------------------------------------

  // Kept as its own type so the two directions stay apart
  typedef struct packed {
    mem_op_e                    op;
    logic [`MEM_OPAQ_BITS-1:0] opaque;
    logic [`MEM_ADDR_BITS-1:0] addr;
    logic [`MEM_LEN_BITS-1:0]  len;
    logic [`MEM_DATA_BITS-1:0] data;
  } mem_resp_t;

endpackage

//--- hdl/msg_fifo.sv
// ------------------------------------------------
// Message FIFO
// Circular buffer of a parameter message type
// with an occupancy count and free slot count
// ------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module msg_fifo
  import mem_msg_pkg::*;
#(
  parameter type t_msg = mem_req_t,
  parameter int  depth = `MSG_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         rst,

  input  logic                         push,
  input  t_msg                         push_msg,
  output logic                         not_full,

  input  logic                         pop,
  output t_msg                         pop_msg,
  output logic                         not_empty,

  output logic [$clog2(depth+1)-1:0]   free
);

  localparam int cnt_bits = $clog2(depth + 1);
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

  t_msg                buf_mem [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;

  logic do_push;
  logic do_pop;

  assign not_full  = (count != cnt_bits'(depth));
  assign not_empty = (count != '0);
  assign free      = cnt_bits'(depth) - count;

  // A full queue still takes a push when the head leaves this cycle
  assign do_pop  = pop && not_empty;
  assign do_push = push && (not_full || do_pop);

  assign pop_msg = buf_mem[rd_ptr];

  // ------------------------------------------------
  // Pointers and count
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      buf_mem[wr_ptr] <= push_msg;
    end
  end

endmodule

//--- hdl/mem_word_array.sv
// ------------------------------------------------
// Word array
// Registered read port, byte-masked write port
// ------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_word_array (
  input  logic                        clk,

  input  logic                        rd_en,
  input  logic                        wr_en,
  input  logic [`MEM_INDEX_BITS-1:0]  index,
  input  logic [`MEM_LEN_BITS-1:0]    byte_en,
  input  logic [`MEM_DATA_BITS-1:0]   wr_data,

  output logic [`MEM_DATA_BITS-1:0]   rd_data
);

  localparam int byte_bits = `MEM_DATA_BITS / `MEM_LEN_BITS;

  logic [`MEM_DATA_BITS-1:0] words [`MEM_WORDS];

  // ------------------------------------------------
  // Write port
  // ------------------------------------------------

  // Only the bytes with their enable set change
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `MEM_LEN_BITS; b++) begin
        if (byte_en[b]) begin
          words[index][b*byte_bits +: byte_bits] <= wr_data[b*byte_bits +: byte_bits];
        end
      end
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------

  // Holds its last value while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= words[index];
    end
  end

endmodule

//--- hdl/mem_server_ctrl.sv
// ------------------------------------------------
// Memory server control
// Two-stage pipeline: issue on the array, then
// build and push the response
// ------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_server_ctrl
  import mem_msg_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,

  // Request queue head
  input  logic                                  req_ready,
  input  mem_req_t                              req_head,
  output logic                                  req_pop,

  // Response queue side
  input  logic [$clog2(`MSG_FIFO_DEPTH+1)-1:0]  resp_free,
  input  logic                                  resp_pop,
  output logic                                  resp_push,
  output mem_resp_t                             resp_out,

  // Word array
  output logic                                  arr_rd_en,
  output logic                                  arr_wr_en,
  output logic [`MEM_INDEX_BITS-1:0]            arr_index,
  output logic [`MEM_LEN_BITS-1:0]              arr_byte_en,
  output logic [`MEM_DATA_BITS-1:0]             arr_wr_data,
  input  logic [`MEM_DATA_BITS-1:0]             arr_rd_data
);

  // ------------------------------------------------
  // Stage 2 registers
  // ------------------------------------------------

  logic                       s2_valid;
  mem_op_e                    s2_op;
  logic [`MEM_OPAQ_BITS-1:0] s2_opaque;
  logic [`MEM_ADDR_BITS-1:0] s2_addr;
  logic [`MEM_LEN_BITS-1:0]  s2_len;

  logic can_push;
  logic stall;
  logic s1_fire;

  // ------------------------------------------------
  // Flow control
  // ------------------------------------------------

  // A slot is free now, or the head leaves the response queue this cycle
  assign can_push = (resp_free != '0) || resp_pop;

  // Stage 2 holding a response with nowhere to go freezes both stages
  assign stall = s2_valid && !can_push;

  assign resp_push = s2_valid && can_push;

  // Stage 1 takes the head whenever stage 2 drains or is empty
  assign s1_fire = req_ready && !stall;
  assign req_pop = s1_fire;

  // ------------------------------------------------
  // Stage 1: decode and issue
  // ------------------------------------------------

  assign arr_rd_en   = s1_fire && (req_head.op == MEM_READ);
  assign arr_wr_en   = s1_fire && (req_head.op == MEM_WRITE);
  assign arr_index   = req_head.addr[`MEM_INDEX_BITS+1:2];
  assign arr_byte_en = req_head.len;
  assign arr_wr_data = req_head.data;

  // ------------------------------------------------
  // Stage 2: hold request while read data returns
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s2_valid <= s1_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_fire) begin
      s2_op     <= req_head.op;
      s2_opaque <= req_head.opaque;
      s2_addr   <= req_head.addr;
      s2_len    <= req_head.len;
    end
  end

  // Response echoes the request, data only for reads
  always_comb begin
    resp_out.op     = s2_op;
    resp_out.opaque = s2_opaque;
    resp_out.addr   = s2_addr;
    resp_out.len    = s2_len;
    if (s2_op == MEM_READ) begin
      resp_out.data = arr_rd_data;
    end else begin
      resp_out.data = '0;
    end
  end

endmodule

//--- hdl/mem_server.sv
// ------------------------------------------------
// Memory server top
// Request queue, control pipeline, word array
// and response queue
// ------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_server
  import mem_msg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      req_val,
  output logic      req_rdy,
  input  mem_req_t  req_msg,

  output logic      resp_val,
  input  logic      resp_rdy,
  output mem_resp_t resp_msg
);

  localparam int cnt_bits = $clog2(`MSG_FIFO_DEPTH + 1);

  // Request side
  logic                req_push;
  logic                req_not_empty;
  mem_req_t            req_head;
  logic                req_pop;

  // Response side
  logic                resp_push;
  mem_resp_t           resp_in;
  logic                resp_pop;
  logic [cnt_bits-1:0] resp_free;

  // Array side
  logic                       arr_rd_en;
  logic                       arr_wr_en;
  logic [`MEM_INDEX_BITS-1:0] arr_index;
  logic [`MEM_LEN_BITS-1:0]   arr_byte_en;
  logic [`MEM_DATA_BITS-1:0]  arr_wr_data;
  logic [`MEM_DATA_BITS-1:0]  arr_rd_data;

  // Channel transfers
  assign req_push = req_val && req_rdy;
  assign resp_pop = resp_val && resp_rdy;

  // ------------------------------------------------
  // Instances
  // ------------------------------------------------

  msg_fifo #(
    .t_msg     (mem_req_t),
    .depth     (`MSG_FIFO_DEPTH)
  ) req_queue (
    .clk       (clk),
    .rst       (rst),
    .push      (req_push),
    .push_msg  (req_msg),
    .not_full  (req_rdy),
    .pop       (req_pop),
    .pop_msg   (req_head),
    .not_empty (req_not_empty),
    .free      ()
  );

  mem_server_ctrl ctrl (
    .clk         (clk),
    .rst         (rst),
    .req_ready   (req_not_empty),
    .req_head    (req_head),
    .req_pop     (req_pop),
    .resp_free   (resp_free),
    .resp_pop    (resp_pop),
    .resp_push   (resp_push),
    .resp_out    (resp_in),
    .arr_rd_en   (arr_rd_en),
    .arr_wr_en   (arr_wr_en),
    .arr_index   (arr_index),
    .arr_byte_en (arr_byte_en),
    .arr_wr_data (arr_wr_data),
    .arr_rd_data (arr_rd_data)
  );

  mem_word_array words (
    .clk     (clk),
    .rd_en   (arr_rd_en),
    .wr_en   (arr_wr_en),
    .index   (arr_index),
    .byte_en (arr_byte_en),
    .wr_data (arr_wr_data),
    .rd_data (arr_rd_data)
  );

  msg_fifo #(
    .t_msg     (mem_resp_t),
    .depth     (`MSG_FIFO_DEPTH)
  ) resp_queue (
    .clk       (clk),
    .rst       (rst),
    .push      (resp_push),
    .push_msg  (resp_in),
    .not_full  (),
    .pop       (resp_pop),
    .pop_msg   (resp_msg),
    .not_empty (resp_val),
    .free      (resp_free)
  );

endmodule

//--- verification/mem_server_checker.sv
// ------------------------------------------------
// Memory server checker
// Byte model of the array, expected response queue
// and channel comparisons
// ------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_server_checker
  import mem_msg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req_val,
  input  logic      req_rdy,
  input  mem_req_t  req_msg,
  input  logic      resp_val,
  input  logic      resp_rdy,
  input  mem_resp_t resp_msg,
  output int        err_count,
  output int        req_count,
  output int        resp_count,
  output logic      saw_full
);

  logic [7:0] mem_bytes [`MEM_WORDS][`MEM_LEN_BITS];
  logic       known     [`MEM_WORDS][`MEM_LEN_BITS];

  mem_resp_t                exp_q  [$];
  logic [`MEM_LEN_BITS-1:0] mask_q [$];

  logic rst_q;

  initial begin
    err_count  = 0;
    req_count  = 0;
    resp_count = 0;
    saw_full   = 1'b0;
    rst_q      = 1'b0;
    for (int w = 0; w < `MEM_WORDS; w++) begin
      for (int b = 0; b < `MEM_LEN_BITS; b++) begin
        known[w][b] = 1'b0;
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %s: got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  // ------------------------------------------------
  // Sampling on the rising edge
  // ------------------------------------------------

  always @(posedge clk) begin
    mem_resp_t                exp;
    logic [`MEM_LEN_BITS-1:0] mask;
    logic [7:0]               idx;

    // Previous edge had reset, so the queues are empty now
    if (rst_q) begin
      compare_value("resp_val", resp_val, 32'h0);
      compare_value("req_rdy", req_rdy, 32'h1);
    end
    rst_q <= rst;

    if (!rst && resp_val && resp_rdy) begin
      resp_count++;
      if (exp_q.size() == 0) begin
        $display("A response appeared before any request was waiting for it");
        err_count++;
      end else begin
        exp  = exp_q.pop_front();
        mask = mask_q.pop_front();
        compare_value("op", resp_msg.op, exp.op);
        compare_value("opaque", resp_msg.opaque, exp.opaque);
        compare_value("addr", resp_msg.addr, exp.addr);
        compare_value("len", resp_msg.len, exp.len);
        if (exp.op == MEM_WRITE) begin
          compare_value("data", resp_msg.data, 32'h0);
        end else begin
          // Bytes never written are skipped
          for (int b = 0; b < `MEM_LEN_BITS; b++) begin
            if (mask[b]) begin
              compare_value($sformatf("data byte %0d", b), resp_msg.data[b*8 +: 8],
                            exp.data[b*8 +: 8]);
            end
          end
        end
      end
    end

    if (!rst && req_val && req_rdy) begin
      req_count++;
      idx        = req_msg.addr[9:2];
      exp.op     = req_msg.op;
      exp.opaque = req_msg.opaque;
      exp.addr   = req_msg.addr;
      exp.len    = req_msg.len;
      exp.data   = '0;
      mask       = '0;
      for (int b = 0; b < `MEM_LEN_BITS; b++) begin
        if (req_msg.op == MEM_WRITE && req_msg.len[b]) begin
          mem_bytes[idx][b] = req_msg.data[b*8 +: 8];
          known[idx][b]     = 1'b1;
        end else if (req_msg.op == MEM_READ) begin
          exp.data[b*8 +: 8] = mem_bytes[idx][b];
          mask[b]            = known[idx][b];
        end
      end
      exp_q.push_back(exp);
      mask_q.push_back(mask);
    end

    if (!rst && req_rdy === 1'b0) begin
      saw_full <= 1'b1;
    end
  end

endmodule

//--- verification/mem_server_tb.sv
// ------------------------------------------------
// Memory server testbench
// Random requests and response back-pressure
// ------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_server_tb
  import mem_msg_pkg::*;
;

  localparam int num_reqs       = 400;
  localparam int timeout_cycles = num_reqs * 12 + 200;

  logic      clk;
  logic      rst;
  logic      req_val;
  logic      req_rdy;
  mem_req_t  req_msg;
  logic      resp_val;
  logic      resp_rdy;
  mem_resp_t resp_msg;

  int   err_count;
  int   req_count;
  int   resp_count;
  logic saw_full;

  int seed;
  int rdy_seed;
  int burst_left;
  int cycles;

  mem_server dut (
    .clk      (clk),
    .rst      (rst),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  mem_server_checker checks (
    .clk        (clk),
    .rst        (rst),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .req_msg    (req_msg),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .resp_msg   (resp_msg),
    .err_count  (err_count),
    .req_count  (req_count),
    .resp_count (resp_count),
    .saw_full   (saw_full)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int percent(inout int s);
    percent = {$random(s)} % 100;
  endfunction

  // 16-word window, a quarter of them with random upper bits
  function automatic mem_req_t random_req(input int n);
    mem_req_t m;
    m.op            = mem_op_e'($random(seed) & 1);
    m.opaque        = $random(seed);
    m.len           = $random(seed);
    m.data          = $random(seed) ^ (n << 20);
    m.addr          = '0;
    m.addr[5:2]     = $random(seed);
    if (percent(seed) < 25) begin
      m.addr[31:10] = $random(seed);
    end
    random_req = m;
  endfunction

  task automatic send_req(input mem_req_t m);
    req_val = 1'b1;
    req_msg = m;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // ------------------------------------------------
  // Response ready, random gaps and long bursts low
  // ------------------------------------------------

  always @(negedge clk) begin
    if (rst) begin
      resp_rdy   = 1'b0;
      burst_left = 0;
    end else if (burst_left > 0) begin
      resp_rdy   = 1'b0;
      burst_left = burst_left - 1;
    end else if (percent(rdy_seed) < 1) begin
      resp_rdy   = 1'b0;
      burst_left = 19;
    end else begin
      resp_rdy   = (percent(rdy_seed) >= 30);
    end
  end

  // Timeout
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, not all responses arrived", cycles);
      $display("errors %0d, responses %0d of %0d", err_count, resp_count, num_reqs);
      $display("sim failed");
      $finish;
    end
  end

  // ------------------------------------------------
  // Stimulus and final report
  // ------------------------------------------------

  initial begin
    int extra;
    seed       = 2;
    rdy_seed   = seed ^ 32'h5a5a;
    cycles     = 0;
    extra      = 0;
    rst        = 1'b1;
    req_val    = 1'b0;
    req_msg    = '0;
    resp_rdy   = 1'b0;
    burst_left = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < num_reqs; i++) begin
      while (percent(seed) < 30) @(negedge clk);
      send_req(random_req(i));
    end

    while (resp_count < num_reqs) @(posedge clk);
    // Catch any duplicate responses
    repeat (20) @(posedge clk);

    if (req_count != num_reqs) begin
      $display("Only %0d of %0d requests were accepted", req_count, num_reqs);
      extra++;
    end
    if (!saw_full) begin
      $display("Request channel never stalled under response back-pressure");
      extra++;
    end

    $display("errors %0d, responses %0d of %0d", err_count + extra, resp_count, num_reqs);
    if (err_count + extra == 0 && resp_count == num_reqs) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+hdl
hdl/mem_msg_pkg.sv
hdl/msg_fifo.sv
hdl/mem_word_array.sv
hdl/mem_server_ctrl.sv
hdl/mem_server.sv
verification/mem_server_checker.sv
verification/mem_server_tb.sv
